//--- Bender.yml
package:
  name: qft3

sources:
  - files:
      - design/qft_pkg.sv
      - design/qft_butterfly.sv
      - design/qft_hadamard_stage.sv
      - design/qft_phase_rotator.sv
      - design/qft_sequencer.sv
      - design/qft_amplitude_file.sv
      - design/qft3_top.sv
  - target: test
    files:
      - testbench/qft_tb.sv

//--- design/qft3_top.sv
`timescale 1ns/1ps

module qft3_top (
	input logic clk,
	input logic rst,
	input qft_pkg::cplx_vec_t samples_i,
	output qft_pkg::cplx_vec_t amps_o
);

	qft_pkg::qft_step_t step;
	qft_pkg::cplx_vec_t state_vec;
	qft_pkg::cplx_vec_t had_vec;
	qft_pkg::cplx_vec_t rot_vec;

	qft_sequencer sequencer_i (
		.clk(clk),
		.rst(rst),
		.step_o(step)
	);

	// State register, updated every edge by the current step
	qft_amplitude_file amp_file_i (
		.clk(clk),
		.rst(rst),
		.step_i(step),
		.samples_i(samples_i),
		.had_i(had_vec),
		.rot_i(rot_vec),
		.state_o(state_vec)
	);

	// Both datapath stages are combinational
	qft_hadamard_stage hadamard_i (
		.step_i(step),
		.state_i(state_vec),
		.had_o(had_vec)
	);

	qft_phase_rotator rotator_i (
		.step_i(step),
		.state_i(state_vec),
		.rot_o(rot_vec)
	);

	assign amps_o = state_vec;

endmodule

//--- design/qft_amplitude_file.sv
`timescale 1ns/1ps

module qft_amplitude_file (
	input logic clk,
	input logic rst,
	input qft_pkg::qft_step_t step_i,
	input qft_pkg::cplx_vec_t samples_i,
	input qft_pkg::cplx_vec_t had_i,
	input qft_pkg::cplx_vec_t rot_i,
	output qft_pkg::cplx_vec_t state_o
);

	qft_pkg::cplx_vec_t next_vec;
	qft_pkg::amp_mask_t ld_en;

	// Final swap of qubits 2 and 0 is a bit reversal of the index
	function automatic logic [2:0] bit_rev(input logic [2:0] k);
		return {k[0], k[1], k[2]};
	endfunction

	// Per-amplitude load enables and next values
	always_comb begin
		next_vec = state_o;
		ld_en = '0;
		case (step_i.op)
			qft_pkg::OP_LOAD: begin
				next_vec = samples_i;
				ld_en = '1;
			end
			qft_pkg::OP_HAD: begin
				next_vec = had_i;
				ld_en = '1;
			end
			qft_pkg::OP_ROT_I, qft_pkg::OP_ROT_C: begin
				next_vec = rot_i;
				ld_en = step_i.mask;
			end
			qft_pkg::OP_SWAP: begin
				for (int k = 0; k < qft_pkg::N_AMP; k++) begin
					next_vec[k] = state_o[bit_rev(3'(k))];
				end
				ld_en = '1;
			end
			default: ld_en = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_o <= '0;
		end else begin
			for (int k = 0; k < qft_pkg::N_AMP; k++) begin
				if (ld_en[k]) begin
					state_o[k] <= next_vec[k];
				end
			end
		end
	end

	// Result must hold once the schedule has gone idle
	a_idle_hold: assert property (@(posedge clk) disable iff (rst)
		(step_i.op == qft_pkg::OP_IDLE) |=> $stable(state_o));

endmodule

//--- design/qft_butterfly.sv
`timescale 1ns/1ps

module qft_butterfly (
	input qft_pkg::cplx_t a_i,
	input qft_pkg::cplx_t b_i,
	output qft_pkg::cplx_t sum_o,
	output qft_pkg::cplx_t diff_o
);

	qft_pkg::sum_t add_re;
	qft_pkg::sum_t add_im;
	qft_pkg::sum_t sub_re;
	qft_pkg::sum_t sub_im;

	// Scale by 1/sqrt(2) and drop back to the sample format, wrapping on overflow
	function automatic qft_pkg::sample_t scale(input qft_pkg::sum_t x);
		qft_pkg::prod_t prod;
		prod = x * qft_pkg::HAD_SCALE;
		prod = prod >>> qft_pkg::FRAC_W;
		return prod[qft_pkg::SAMPLE_W-1:0];
	endfunction

	// One extra bit so the sum and difference cannot overflow
	assign add_re = a_i.re + b_i.re;
	assign add_im = a_i.im + b_i.im;
	assign sub_re = a_i.re - b_i.re;
	assign sub_im = a_i.im - b_i.im;

	assign sum_o.re = scale(add_re);
	assign sum_o.im = scale(add_im);
	assign diff_o.re = scale(sub_re);
	assign diff_o.im = scale(sub_im);

endmodule

//--- design/qft_hadamard_stage.sv
`timescale 1ns/1ps

module qft_hadamard_stage (
	input qft_pkg::qft_step_t step_i,
	input qft_pkg::cplx_vec_t state_i,
	output qft_pkg::cplx_vec_t had_o
);

	qft_pkg::cplx_t a_vec [4];
	qft_pkg::cplx_t b_vec [4];
	qft_pkg::cplx_t sum_vec [4];
	qft_pkg::cplx_t diff_vec [4];

	// Lower index of pair j: bit q cleared, the other two bits taken from j
	function automatic logic [2:0] lo_index(input logic [1:0] q, input logic [1:0] j);
		logic [2:0] idx;
		case (q)
			2'd0: idx = {j, 1'b0};
			2'd1: idx = {j[1], 1'b0, j[0]};
			default: idx = {1'b0, j};
		endcase
		return idx;
	endfunction

	function automatic logic [2:0] hi_index(input logic [1:0] q, input logic [1:0] j);
		logic [2:0] idx;
		idx = lo_index(q, j);
		idx[q] = 1'b1;
		return idx;
	endfunction

	// Gather the pairs for the target qubit
	always_comb begin
		for (int j = 0; j < 4; j++) begin
			a_vec[j] = state_i[lo_index(step_i.qubit, 2'(j))];
			b_vec[j] = state_i[hi_index(step_i.qubit, 2'(j))];
		end
	end

	for (genvar j = 0; j < 4; j++) begin : g_bfly
		qft_butterfly bfly_i (
			.a_i(a_vec[j]),
			.b_i(b_vec[j]),
			.sum_o(sum_vec[j]),
			.diff_o(diff_vec[j])
		);
	end

	// Scatter results back to the indices they came from
	always_comb begin
		had_o = state_i;
		for (int j = 0; j < 4; j++) begin
			had_o[lo_index(step_i.qubit, 2'(j))] = sum_vec[j];
			had_o[hi_index(step_i.qubit, 2'(j))] = diff_vec[j];
		end
	end

endmodule

//--- design/qft_phase_rotator.sv
`timescale 1ns/1ps

module qft_phase_rotator (
	input qft_pkg::qft_step_t step_i,
	input qft_pkg::cplx_vec_t state_i,
	output qft_pkg::cplx_vec_t rot_o
);

	// R2 is a quarter turn, so no multiplier is needed
	function automatic qft_pkg::cplx_t mul_i(input qft_pkg::cplx_t x);
		qft_pkg::cplx_t y;
		y.re = -x.im;
		y.im = x.re;
		return y;
	endfunction

	// Full complex product, truncated back to the sample format
	function automatic qft_pkg::cplx_t mul_const(
		input qft_pkg::cplx_t x,
		input qft_pkg::cplx_t c
	);
		qft_pkg::prod_t acc_re;
		qft_pkg::prod_t acc_im;
		qft_pkg::cplx_t y;
		acc_re = x.re * c.re - x.im * c.im;
		acc_im = x.re * c.im + x.im * c.re;
		acc_re = acc_re >>> qft_pkg::FRAC_W;
		acc_im = acc_im >>> qft_pkg::FRAC_W;
		y.re = acc_re[qft_pkg::SAMPLE_W-1:0];
		y.im = acc_im[qft_pkg::SAMPLE_W-1:0];
		return y;
	endfunction

	// Every amplitude is rotated, the amplitude file picks the masked ones
	always_comb begin
		for (int k = 0; k < qft_pkg::N_AMP; k++) begin
			if (step_i.op == qft_pkg::OP_ROT_I) begin
				rot_o[k] = mul_i(state_i[k]);
			end else begin
				rot_o[k] = mul_const(state_i[k], qft_pkg::ROT_PI4);
			end
		end
	end

endmodule

//--- design/qft_pkg.sv
package qft_pkg;

	// Fixed-point format of one real or imaginary component
	localparam int SAMPLE_W = 24;
	localparam int FRAC_W = 22;

	// Three qubits give eight amplitudes
	localparam int N_QUBIT = 3;
	localparam int N_AMP = 8;

	// Intermediate widths for butterflies and complex products
	localparam int SUM_W = SAMPLE_W + 1;
	localparam int PROD_W = 2 * SAMPLE_W + 1;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [SUM_W-1:0] sum_t;
	typedef logic signed [PROD_W-1:0] prod_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	// Whole state vector, index bit q belongs to qubit q
	typedef cplx_t [N_AMP-1:0] cplx_vec_t;

	typedef logic [N_AMP-1:0] amp_mask_t;

	// 1/sqrt(2)
	localparam sample_t HAD_SCALE = 24'h2D413C;

	// e^(i*pi/4), used by the R3 layer
	localparam cplx_t ROT_PI4 = '{re: 24'h2D413C, im: 24'h2D413C};

	typedef enum logic [2:0] {
		OP_IDLE,
		OP_LOAD,
		OP_HAD,
		OP_ROT_I,
		OP_ROT_C,
		OP_SWAP
	} qft_op_e;

	// Control word for one clock
	typedef struct packed {
		qft_op_e op;
		logic [1:0] qubit;
		amp_mask_t mask;
	} qft_step_t;

endpackage

//--- design/qft_sequencer.sv
`timescale 1ns/1ps

module qft_sequencer (
	input logic clk,
	input logic rst,
	output qft_pkg::qft_step_t step_o
);

	// Step 9 and beyond is idle
	localparam logic [3:0] IDLE_STEP = 4'd9;

	logic [3:0] cnt_q;
	logic [3:0] cnt_next;

	// Fixed schedule for the 3-qubit QFT
	function automatic qft_pkg::qft_step_t step_word(input logic [3:0] n);
		qft_pkg::qft_step_t w;
		w.op = qft_pkg::OP_IDLE;
		w.qubit = 2'd0;
		w.mask = '0;
		case (n)
			4'd1: w.op = qft_pkg::OP_LOAD;
			4'd2: begin
				w.op = qft_pkg::OP_HAD;
				w.qubit = 2'd2;
			end
			4'd3: begin
				w.op = qft_pkg::OP_ROT_I;
				w.mask = 8'b1100_0000;
			end
			4'd4: begin
				w.op = qft_pkg::OP_ROT_C;
				w.mask = 8'b1010_0000;
			end
			4'd5: begin
				w.op = qft_pkg::OP_HAD;
				w.qubit = 2'd1;
			end
			4'd6: begin
				w.op = qft_pkg::OP_ROT_I;
				w.mask = 8'b1000_1000;
			end
			4'd7: begin
				w.op = qft_pkg::OP_HAD;
				w.qubit = 2'd0;
			end
			4'd8: w.op = qft_pkg::OP_SWAP;
			default: w.op = qft_pkg::OP_IDLE;
		endcase
		return w;
	endfunction

	assign cnt_next = (cnt_q == IDLE_STEP) ? cnt_q : cnt_q + 4'd1;

	// The word for step 1 waits in the register while reset is held
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt_q <= 4'd1;
			step_o <= step_word(4'd1);
		end else begin
			cnt_q <= cnt_next;
			step_o <= step_word(cnt_next);
		end
	end

	a_rot_mask: assert property (@(posedge clk) disable iff (rst)
		(step_o.op inside {qft_pkg::OP_ROT_I, qft_pkg::OP_ROT_C}) |-> (step_o.mask != '0));

	a_had_qubit: assert property (@(posedge clk) disable iff (rst)
		(step_o.op == qft_pkg::OP_HAD) |-> (step_o.qubit < qft_pkg::N_QUBIT));

endmodule

//--- testbench/qft_tb.sv
`timescale 1ns/1ps

module qft_tb;

	localparam int CLK_PERIOD = 4;
	localparam int RUN_CYCLES = 14;
	localparam int N_BASIS = 8;
	localparam int N_RANDOM = 200;
	// Basis and random runs, plus hold, aborted run and the run after it
	localparam int N_RUNS = N_BASIS + N_RANDOM + 3;
	localparam int FRAC = 22;
	localparam longint HAD_Q22 = 64'h2D413C;
	localparam longint ROT_Q22 = 64'h2D413C;
	// 1/(2*sqrt(2)) in Q1.22
	localparam longint UNIFORM_Q22 = 1482910;

	logic clk;
	logic rst;
	qft_pkg::cplx_vec_t samples_i;
	qft_pkg::cplx_vec_t amps_o;

	qft_pkg::cplx_vec_t exp_vec;
	logic check_en;
	string test_name;

	qft3_top qft3_top_i (
		.clk(clk),
		.rst(rst),
		.samples_i(samples_i),
		.amps_o(amps_o)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [23:0] narrow(input longint x);
		return x[23:0];
	endfunction

	function automatic qft_pkg::cplx_vec_t hadamard_layer(input qft_pkg::cplx_vec_t v, input int q);
		qft_pkg::cplx_vec_t r;
		int hi;
		r = v;
		for (int k = 0; k < 8; k++) begin
			if (((k >> q) & 1) == 0) begin
				hi = k + (1 << q);
				r[k].re = narrow(((longint'(v[k].re) + longint'(v[hi].re)) * HAD_Q22) >>> FRAC);
				r[k].im = narrow(((longint'(v[k].im) + longint'(v[hi].im)) * HAD_Q22) >>> FRAC);
				r[hi].re = narrow(((longint'(v[k].re) - longint'(v[hi].re)) * HAD_Q22) >>> FRAC);
				r[hi].im = narrow(((longint'(v[k].im) - longint'(v[hi].im)) * HAD_Q22) >>> FRAC);
			end
		end
		return r;
	endfunction

	function automatic qft_pkg::cplx_vec_t times_i_layer(input qft_pkg::cplx_vec_t v,
			input logic [7:0] mask);
		qft_pkg::cplx_vec_t r;
		r = v;
		for (int k = 0; k < 8; k++) begin
			if (mask[k]) begin
				r[k].re = narrow(-longint'(v[k].im));
				r[k].im = v[k].re;
			end
		end
		return r;
	endfunction

	function automatic qft_pkg::cplx_vec_t pi4_layer(input qft_pkg::cplx_vec_t v,
			input logic [7:0] mask);
		qft_pkg::cplx_vec_t r;
		longint re;
		longint im;
		r = v;
		for (int k = 0; k < 8; k++) begin
			if (mask[k]) begin
				re = v[k].re;
				im = v[k].im;
				r[k].re = narrow((re * ROT_Q22 - im * ROT_Q22) >>> FRAC);
				r[k].im = narrow((re * ROT_Q22 + im * ROT_Q22) >>> FRAC);
			end
		end
		return r;
	endfunction

	// Swap of qubits 2 and 0
	function automatic qft_pkg::cplx_vec_t swap_qubits(input qft_pkg::cplx_vec_t v);
		qft_pkg::cplx_vec_t r;
		logic [2:0] idx;
		for (int k = 0; k < 8; k++) begin
			idx = k[2:0];
			r[k] = v[{idx[0], idx[1], idx[2]}];
		end
		return r;
	endfunction

	function automatic qft_pkg::cplx_vec_t qft_ref(input qft_pkg::cplx_vec_t v);
		qft_pkg::cplx_vec_t s;
		s = hadamard_layer(v, 2);
		s = times_i_layer(s, 8'b1100_0000);
		s = pi4_layer(s, 8'b1010_0000);
		s = hadamard_layer(s, 1);
		s = times_i_layer(s, 8'b1000_1000);
		s = hadamard_layer(s, 0);
		s = swap_qubits(s);
		return s;
	endfunction

	task automatic check_val(input string name, input logic [47:0] expected,
			input logic [47:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("Regression failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	// Compare every amplitude while a check window is open
	always @(negedge clk) begin
		if (check_en) begin
			for (int k = 0; k < 8; k++) begin
				check_val($sformatf("%s amp %0d", test_name, k), exp_vec[k], amps_o[k]);
			end
		end
	end

	task automatic drive_edge();
		@(posedge clk);
		#1;
	endtask

	// Component in the range -0.25 to +0.25
	function automatic logic [23:0] rand_comp();
		int r;
		r = int'($urandom % 32'h0020_0001) - 32'h0010_0000;
		return r[23:0];
	endfunction

	function automatic qft_pkg::cplx_vec_t random_vec();
		qft_pkg::cplx_vec_t v;
		for (int k = 0; k < 8; k++) begin
			v[k].re = rand_comp();
			v[k].im = rand_comp();
		end
		return v;
	endfunction

	function automatic qft_pkg::cplx_vec_t basis_vec(input int n);
		qft_pkg::cplx_vec_t v;
		v = '0;
		v[n].re = 24'h400000;
		return v;
	endfunction

	// Reset for two cycles, release, then let edge 1 load the input
	task automatic start_run(input string name, input qft_pkg::cplx_vec_t vec);
		drive_edge();
		rst = 1'b1;
		samples_i = vec;
		exp_vec = '0;
		test_name = {name, " reset"};
		check_en = 1'b1;
		repeat (2) drive_edge();
		rst = 1'b0;
		drive_edge();
		check_en = 1'b0;
	endtask

	task automatic run_vector(input string name, input qft_pkg::cplx_vec_t vec);
		start_run(name, vec);
		// Edges 2 to 8 apply the gate layers and the swap
		repeat (7) drive_edge();
		exp_vec = qft_ref(vec);
		test_name = name;
		check_en = 1'b1;
		repeat (2) drive_edge();
	endtask

	task automatic check_uniform(input qft_pkg::cplx_vec_t v);
		longint d;
		logic near;
		for (int k = 0; k < 8; k++) begin
			d = longint'(v[k].re) - UNIFORM_Q22;
			near = (d >= -16) && (d <= 16) && (v[k].im == 0);
			check_val($sformatf("basis_0 uniform amp %0d", k), 48'd1, {47'd0, near});
		end
	endtask

	initial begin
		#(N_RUNS * RUN_CYCLES * CLK_PERIOD * 2);
		$display("Timeout: the regression did not finish in the expected time");
		$display("Regression failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		void'($urandom(32'h9d8d_8527));
		rst = 1'b1;
		samples_i = '0;
		exp_vec = '0;
		check_en = 1'b0;
		test_name = "init";

		for (int n = 0; n < N_BASIS; n++) begin
			run_vector($sformatf("basis_%0d", n), basis_vec(n));
			if (n == 0) begin
				check_uniform(amps_o);
			end
		end

		for (int n = 0; n < N_RANDOM; n++) begin
			run_vector($sformatf("random_%0d", n), random_vec());
		end

		// New input after completion must not disturb the result
		run_vector("hold", random_vec());
		samples_i = random_vec();
		test_name = "hold after input change";
		repeat (10) drive_edge();

		// Reset in the middle of a run
		start_run("abort", random_vec());
		repeat (3) drive_edge();
		rst = 1'b1;
		exp_vec = '0;
		test_name = "abort mid-run reset";
		check_en = 1'b1;
		repeat (2) drive_edge();
		run_vector("after abort", random_vec());

		$display("Regression passed");
		$finish;
	end

endmodule

//--- verilog.f
design/qft_pkg.sv
design/qft_butterfly.sv
design/qft_hadamard_stage.sv
design/qft_phase_rotator.sv
design/qft_sequencer.sv
design/qft_amplitude_file.sv
design/qft3_top.sv
testbench/qft_tb.sv
